//--- hw/rv_pkg.sv
package rv_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [31:0] instr_t;
  typedef logic [4:0] reg_addr_t;
  typedef logic [2:0] funct3_t;
  typedef logic [3:0] strb_t;
  typedef logic [3:0] alu_op_t;
  typedef logic [1:0] res_src_t;
  typedef logic [1:0] a_src_t;

  // --------------------
  // Opcodes
  // --------------------
  localparam logic [6:0] op_lui = 7'b0110111;
  localparam logic [6:0] op_auipc = 7'b0010111;
  localparam logic [6:0] op_jal = 7'b1101111;
  localparam logic [6:0] op_jalr = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load = 7'b0000011;
  localparam logic [6:0] op_store = 7'b0100011;
  localparam logic [6:0] op_imm = 7'b0010011;
  localparam logic [6:0] op_reg = 7'b0110011;
  localparam logic [6:0] op_system = 7'b1110011;

  localparam instr_t instr_ebreak = 32'h0010_0073;
  localparam word_t reset_pc = '0;

  // --------------------
  // ALU operations
  // --------------------
  localparam alu_op_t alu_add = 4'd0;
  localparam alu_op_t alu_sub = 4'd1;
  localparam alu_op_t alu_and = 4'd2;
  localparam alu_op_t alu_or = 4'd3;
  localparam alu_op_t alu_xor = 4'd4;
  localparam alu_op_t alu_slt = 4'd5;
  localparam alu_op_t alu_sltu = 4'd6;
  localparam alu_op_t alu_sll = 4'd7;
  localparam alu_op_t alu_srl = 4'd8;
  localparam alu_op_t alu_sra = 4'd9;
  localparam alu_op_t alu_pass_b = 4'd10;

  // Writeback and operand A sources
  localparam res_src_t res_alu = 2'd0;
  localparam res_src_t res_load = 2'd1;
  localparam res_src_t res_link = 2'd2;

  localparam a_src_t a_rs1 = 2'd0;
  localparam a_src_t a_zero = 2'd1;
  localparam a_src_t a_pc = 2'd2;

  typedef struct packed {
    logic      reg_write;
    logic      mem_write;
    logic      mem_read;
    a_src_t    a_src;
    logic      b_imm;
    res_src_t  res_src;
    logic      is_branch;
    logic      is_jump;
    logic      jalr;
    logic      alu_imm;
    reg_addr_t rd;
    funct3_t   funct3;
    logic      funct7_b5;
  } ctrl_t;

endpackage

//--- hw/rv_pc.sv
`timescale 1ns/100ps

module rv_pc (
  input  logic          clk,
  input  logic          rst,
  input  logic          halt,
  input  logic          pc_sel,
  input  rv_pkg::word_t target,
  output rv_pkg::word_t pc,
  output rv_pkg::word_t pc_plus4
);
  import rv_pkg::*;

  assign pc_plus4 = pc + word_t'(4);

  // Halt freezes the PC on EBREAK
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= reset_pc;
    end else if (!halt) begin
      pc <= pc_sel ? target : pc_plus4;
    end
  end

endmodule

//--- hw/rv_idec.sv
`timescale 1ns/100ps

module rv_idec (
  input  rv_pkg::instr_t    instr,
  output rv_pkg::ctrl_t     ctrl,
  output rv_pkg::reg_addr_t rs1,
  output rv_pkg::reg_addr_t rs2,
  output rv_pkg::word_t     imm,
  output logic              is_ebreak
);
  import rv_pkg::*;

  logic [6:0] opcode;
  word_t imm_i;
  word_t imm_s;
  word_t imm_b;
  word_t imm_u;
  word_t imm_j;

  assign opcode = instr[6:0];
  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];
  assign is_ebreak = (instr == instr_ebreak);

  // --------------------
  // Immediate formats
  // --------------------
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // --------------------
  // Control decode
  // --------------------
  always_comb begin
    ctrl = '0;
    ctrl.a_src = a_rs1;
    ctrl.res_src = res_alu;
    ctrl.rd = instr[11:7];
    ctrl.funct3 = instr[14:12];
    ctrl.funct7_b5 = instr[30];
    imm = imm_i;

    case (opcode)
      op_lui: begin
        ctrl.reg_write = 1'b1;
        ctrl.a_src = a_zero;
        ctrl.b_imm = 1'b1;
        imm = imm_u;
      end
      op_auipc: begin
        ctrl.reg_write = 1'b1;
        ctrl.a_src = a_pc;
        ctrl.b_imm = 1'b1;
        imm = imm_u;
      end
      op_jal: begin
        ctrl.reg_write = 1'b1;
        ctrl.a_src = a_pc;
        ctrl.b_imm = 1'b1;
        ctrl.res_src = res_link;
        ctrl.is_jump = 1'b1;
        imm = imm_j;
      end
      op_jalr: begin
        ctrl.reg_write = 1'b1;
        ctrl.b_imm = 1'b1;
        ctrl.res_src = res_link;
        ctrl.is_jump = 1'b1;
        ctrl.jalr = 1'b1;
      end
      op_branch: begin
        ctrl.is_branch = 1'b1;
        imm = imm_b;
      end
      op_load: begin
        ctrl.reg_write = 1'b1;
        ctrl.mem_read = 1'b1;
        ctrl.b_imm = 1'b1;
        ctrl.res_src = res_load;
      end
      op_store: begin
        ctrl.mem_write = 1'b1;
        ctrl.b_imm = 1'b1;
        imm = imm_s;
      end
      op_imm: begin
        ctrl.reg_write = 1'b1;
        ctrl.b_imm = 1'b1;
        ctrl.alu_imm = 1'b1;
      end
      op_reg: ctrl.reg_write = 1'b1;
      // EBREAK is flagged on its own, nothing written
      op_system: ctrl.reg_write = 1'b0;
      default: ctrl.reg_write = 1'b0;
    endcase
  end

endmodule

//--- hw/rv_regfile.sv
`timescale 1ns/100ps

module rv_regfile (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::reg_addr_t rs1,
  input  rv_pkg::reg_addr_t rs2,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data,
  input  logic              we,
  input  rv_pkg::reg_addr_t rd,
  input  rv_pkg::word_t     rd_data
);
  import rv_pkg::*;

  // No storage behind x0
  word_t regs [1:31];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- hw/rv_alu.sv
`timescale 1ns/100ps

module rv_alu (
  input  rv_pkg::ctrl_t ctrl,
  input  rv_pkg::word_t a,
  input  rv_pkg::word_t b,
  output rv_pkg::word_t result
);
  import rv_pkg::*;

  alu_op_t op;
  logic is_alu;
  logic [4:0] shamt;

  // OP-IMM, or a register write without an immediate (OP)
  assign is_alu = ctrl.alu_imm | (ctrl.reg_write & ~ctrl.b_imm);
  assign shamt = b[4:0];

  // --------------------
  // Operation decode
  // --------------------
  always_comb begin
    op = alu_add;
    if (ctrl.a_src == a_zero) begin
      op = alu_pass_b;
    end else if (is_alu) begin
      case (ctrl.funct3)
        3'b000: op = (ctrl.funct7_b5 && !ctrl.alu_imm) ? alu_sub : alu_add;
        3'b001: op = alu_sll;
        3'b010: op = alu_slt;
        3'b011: op = alu_sltu;
        3'b100: op = alu_xor;
        3'b101: op = ctrl.funct7_b5 ? alu_sra : alu_srl;
        3'b110: op = alu_or;
        default: op = alu_and;
      endcase
    end
  end

  always_comb begin
    case (op)
      alu_sub: result = a - b;
      alu_and: result = a & b;
      alu_or: result = a | b;
      alu_xor: result = a ^ b;
      alu_slt: result = word_t'($signed(a) < $signed(b));
      alu_sltu: result = word_t'(a < b);
      alu_sll: result = a << shamt;
      alu_srl: result = a >> shamt;
      alu_sra: result = word_t'($signed(a) >>> shamt);
      alu_pass_b: result = b;
      default: result = a + b;
    endcase
  end

endmodule

//--- hw/rv_bcmp.sv
`timescale 1ns/100ps

module rv_bcmp (
  input  rv_pkg::funct3_t funct3,
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  output logic            taken
);
  logic eq;
  logic lt_s;
  logic lt_u;
  logic cond;

  assign eq = (a == b);
  assign lt_s = ($signed(a) < $signed(b));
  assign lt_u = (a < b);

  // Bit 0 of funct3 inverts the base condition (BNE, BGE, BGEU)
  always_comb begin
    case (funct3[2:1])
      2'b00: cond = eq;
      2'b10: cond = lt_s;
      2'b11: cond = lt_u;
      default: cond = 1'b0;
    endcase
  end

  assign taken = cond ^ funct3[0];

endmodule

//--- hw/rv_mem_fmt.sv
`timescale 1ns/100ps

module rv_mem_fmt (
  input  rv_pkg::funct3_t funct3,
  input  logic            mem_write,
  input  logic [1:0]      addr_lo,
  input  rv_pkg::word_t   st_data,
  output rv_pkg::word_t   wdata,
  output rv_pkg::strb_t   wstrb,
  input  rv_pkg::word_t   rdata,
  output rv_pkg::word_t   ld_data
);
  import rv_pkg::*;

  word_t lane;
  logic ld_sign;

  // --------------------
  // Store placement
  // --------------------
  always_comb begin
    wdata = st_data;
    wstrb = 4'b1111;
    case (funct3[1:0])
      2'b00: begin
        wdata = {4{st_data[7:0]}};
        wstrb = strb_t'(4'b0001 << addr_lo);
      end
      2'b01: begin
        wdata = {2{st_data[15:0]}};
        wstrb = strb_t'(4'b0011 << {addr_lo[1], 1'b0});
      end
      default: wstrb = 4'b1111;
    endcase
    if (!mem_write) begin
      wstrb = '0;
    end
  end

  // --------------------
  // Load extraction
  // --------------------

  // Addressed byte or half moved down to bit 0
  assign lane = rdata >> {addr_lo, 3'b000};

  // LBU and LHU have funct3[2] set
  assign ld_sign = ~funct3[2];

  always_comb begin
    case (funct3[1:0])
      2'b00: ld_data = {{24{lane[7] & ld_sign}}, lane[7:0]};
      2'b01: ld_data = {{16{lane[15] & ld_sign}}, lane[15:0]};
      default: ld_data = rdata;
    endcase
  end

endmodule

//--- hw/rv_core.sv
`timescale 1ns/100ps

module rv_core (
  input  logic           clk,
  input  logic           rst,
  output rv_pkg::word_t  imem_addr,
  input  rv_pkg::instr_t imem_rdata,
  output rv_pkg::word_t  dmem_addr,
  input  rv_pkg::word_t  dmem_rdata,
  output rv_pkg::word_t  dmem_wdata,
  output rv_pkg::strb_t  dmem_wstrb,
  output logic           dmem_re,
  output logic           ebreak
);
  import rv_pkg::*;

  word_t pc;
  word_t pc_plus4;
  word_t target;
  logic pc_sel;
  logic halt;
  logic run;
  ctrl_t ctrl;
  reg_addr_t rs1;
  reg_addr_t rs2;
  word_t imm;
  word_t rs1_data;
  word_t rs2_data;
  word_t alu_a;
  word_t alu_b;
  word_t alu_result;
  word_t ld_data;
  word_t rd_data;
  logic branch_taken;

  // No state changes while halted or held in reset
  assign run = ~halt & ~rst;
  assign ebreak = halt & ~rst;
  assign dmem_re = ctrl.mem_read & ~rst;

  rv_pc u_pc (
    .clk(clk), .rst(rst), .halt(halt), .pc_sel(pc_sel),
    .target(target), .pc(pc), .pc_plus4(pc_plus4)
  );

  assign imem_addr = pc;

  rv_idec u_idec (
    .instr(imem_rdata), .ctrl(ctrl), .rs1(rs1), .rs2(rs2), .imm(imm), .is_ebreak(halt)
  );

  rv_regfile u_regfile (
    .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .we(ctrl.reg_write & run), .rd(ctrl.rd), .rd_data(rd_data)
  );

  // --------------------
  // Execute
  // --------------------
  always_comb begin
    case (ctrl.a_src)
      a_zero: alu_a = '0;
      a_pc: alu_a = pc;
      default: alu_a = rs1_data;
    endcase
  end

  assign alu_b = ctrl.b_imm ? imm : rs2_data;

  rv_alu u_alu (.ctrl(ctrl), .a(alu_a), .b(alu_b), .result(alu_result));

  rv_bcmp u_bcmp (.funct3(ctrl.funct3), .a(rs1_data), .b(rs2_data), .taken(branch_taken));

  // JALR clears bit 0 of rs1 + imm
  assign target = ctrl.jalr ? {alu_result[xlen-1:1], 1'b0} : pc + imm;
  assign pc_sel = (ctrl.is_branch & branch_taken) | ctrl.is_jump;

  // --------------------
  // Memory and writeback
  // --------------------
  assign dmem_addr = alu_result;

  rv_mem_fmt u_mem_fmt (
    .funct3(ctrl.funct3), .mem_write(ctrl.mem_write & run), .addr_lo(alu_result[1:0]),
    .st_data(rs2_data), .wdata(dmem_wdata), .wstrb(dmem_wstrb),
    .rdata(dmem_rdata), .ld_data(ld_data)
  );

  always_comb begin
    case (ctrl.res_src)
      res_load: rd_data = ld_data;
      res_link: rd_data = pc_plus4;
      default: rd_data = alu_result;
    endcase
  end

endmodule

//--- bench/tb_mem.sv
`timescale 1ns/100ps

module tb_mem (
  input  logic           clk,
  input  rv_pkg::word_t  imem_addr,
  output rv_pkg::instr_t imem_rdata,
  input  rv_pkg::word_t  dmem_addr,
  output rv_pkg::word_t  dmem_rdata,
  input  rv_pkg::word_t  dmem_wdata,
  input  rv_pkg::strb_t  dmem_wstrb
);
  import rv_pkg::*;

  // 4 KB of program, 1 KB of data
  instr_t rom [0:1023];
  word_t ram [0:255];

  initial begin
    for (int i = 0; i < 1024; i++) begin
      rom[i] = instr_ebreak;
    end
  end

  // Both reads are combinational, as the core expects
  assign imem_rdata = rom[imem_addr[11:2]];
  assign dmem_rdata = ram[dmem_addr[9:2]];

  // Byte lanes written only where strobed
  always @(posedge clk) begin
    for (int b = 0; b < 4; b++) begin
      if (dmem_wstrb[b]) begin
        ram[dmem_addr[9:2]][8*b +: 8] <= dmem_wdata[8*b +: 8];
      end
    end
  end

endmodule

//--- bench/tb_rv_core.sv
`timescale 1ns/100ps

module tb_rv_core;
  import rv_pkg::*;

  typedef struct packed {
    word_t addr;
    word_t data;
    strb_t strb;
  } store_t;

  logic clk = 1'b0;
  logic rst;
  word_t imem_addr;
  instr_t imem_rdata;
  word_t dmem_addr;
  word_t dmem_rdata;
  word_t dmem_wdata;
  strb_t dmem_wstrb;
  logic dmem_re;
  logic ebreak;

  instr_t prog [0:1023];
  int n_prog;
  store_t exp_q [$];
  store_t chk_e;
  word_t res_addr;
  word_t rnd;
  int errors;
  int tests;
  int failed;
  logic timed_out;
  logic rst_q;

  rv_core u_dut (
    .clk(clk), .rst(rst), .imem_addr(imem_addr), .imem_rdata(imem_rdata),
    .dmem_addr(dmem_addr), .dmem_rdata(dmem_rdata), .dmem_wdata(dmem_wdata),
    .dmem_wstrb(dmem_wstrb), .dmem_re(dmem_re), .ebreak(ebreak)
  );

  tb_mem u_mem (
    .clk(clk), .imem_addr(imem_addr), .imem_rdata(imem_rdata),
    .dmem_addr(dmem_addr), .dmem_rdata(dmem_rdata), .dmem_wdata(dmem_wdata),
    .dmem_wstrb(dmem_wstrb)
  );

  initial begin
    forever #50 clk = ~clk;
  end

  // --------------------
  // Reference rules
  // --------------------
  function automatic word_t xorshift(input word_t x);
    word_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic word_t ram_pattern(input int i);
    return (word_t'(i) * 32'h9e37_79b1) ^ 32'h5a5a_3c3c;
  endfunction

  function automatic word_t sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic word_t alu_ref(input int f3, input logic alt, input word_t a, input word_t b);
    case (f3)
      0: return alt ? a - b : a + b;
      1: return a << b[4:0];
      2: return {31'b0, $signed(a) < $signed(b)};
      3: return {31'b0, a < b};
      4: return a ^ b;
      5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_ref(input int f3, input word_t a, input word_t b);
    case (f3)
      0: return a == b;
      1: return a != b;
      4: return $signed(a) < $signed(b);
      5: return $signed(a) >= $signed(b);
      6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic word_t ld_ref(input int f3, input word_t w, input int off);
    word_t s;
    s = w >> (8 * off);
    case (f3)
      0: return {{24{s[7]}}, s[7:0]};
      4: return {24'b0, s[7:0]};
      1: return {{16{s[15]}}, s[15:0]};
      5: return {16'b0, s[15:0]};
      default: return w;
    endcase
  endfunction

  // --------------------
  // Instruction encoders
  // --------------------
  function automatic instr_t enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                   input int f3, input int rd);
    return {f7, 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), op_reg};
  endfunction

  function automatic instr_t enc_i(input logic [11:0] imm, input int rs1, input int f3,
                                   input int rd, input logic [6:0] op);
    return {imm, 5'(rs1), 3'(f3), 5'(rd), op};
  endfunction

  function automatic instr_t enc_s(input logic [11:0] imm, input int rs2, input int rs1,
                                   input int f3);
    return {imm[11:5], 5'(rs2), 5'(rs1), 3'(f3), imm[4:0], op_store};
  endfunction

  function automatic instr_t enc_b(input logic [12:0] imm, input int rs2, input int rs1,
                                   input int f3);
    return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), 3'(f3), imm[4:1], imm[11], op_branch};
  endfunction

  function automatic instr_t enc_j(input logic [20:0] imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), op_jal};
  endfunction

  // --------------------
  // Program builder
  // --------------------
  task automatic next_rand(output word_t v);
    rnd = xorshift(rnd);
    v = rnd;
  endtask

  task automatic emit(input instr_t ins);
    prog[n_prog] = ins;
    n_prog++;
  endtask

  task automatic start_program();
    n_prog = 0;
    res_addr = 32'h200;
    exp_q.delete();
  endtask

  task automatic load_const(input int rd, input word_t val);
    word_t hi;
    hi = val + 32'h800;
    emit({hi[31:12], 5'(rd), op_lui});
    emit(enc_i(val[11:0], rd, 0, rd, op_imm));
  endtask

  task automatic expect_store(input word_t addr, input word_t data, input strb_t strb);
    exp_q.push_back({addr, data, strb});
  endtask

  // SW of rs into the next result slot
  task automatic store_word(input int rs, input word_t value, input logic expected);
    emit(enc_s(res_addr[11:0], rs, 0, 2));
    if (expected) begin
      expect_store(res_addr, value, 4'b1111);
    end
    res_addr += 4;
  endtask

  // --------------------
  // Checkers
  // --------------------
  task automatic check_value(input string name, input word_t got, input word_t exp);
    assert (got === exp)
    else begin
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  always @(posedge clk) rst_q <= rst;

  always @(negedge clk) begin
    if (rst) begin
      assert (dmem_wstrb == '0 && dmem_re == 1'b0 && ebreak == 1'b0)
      else begin
        $display("%0t: strobe, load or ebreak output active during reset", $time);
        errors++;
      end
      if (rst_q) begin
        check_value("imem_addr", imem_addr, reset_pc);
      end
    end else begin
      check_value("dmem_re", word_t'(dmem_re), word_t'(imem_rdata[6:0] == 7'b0000011));
      if (dmem_wstrb != '0) begin
        assert (exp_q.size() != 0)
        else begin
          $display("%0t: store to %h that the program should not reach", $time, dmem_addr);
          errors++;
        end
        if (exp_q.size() != 0) begin
          chk_e = exp_q.pop_front();
          check_value("dmem_addr", dmem_addr, chk_e.addr);
          check_value("dmem_wdata", dmem_wdata, chk_e.data);
          check_value("dmem_wstrb", word_t'(dmem_wstrb), word_t'(chk_e.strb));
        end
      end
    end
  end

  // Load the program under reset, run to EBREAK, then watch the halt
  task automatic run_program(input string name);
    int cyc;
    int err0;
    word_t hold;
    err0 = errors;
    if (timed_out) begin
      return;
    end
    emit(instr_ebreak);
    @(posedge clk);
    #1 rst = 1'b1;
    for (int i = 0; i < 1024; i++) begin
      u_mem.rom[i] = (i < n_prog) ? prog[i] : instr_ebreak;
    end
    repeat (2) @(posedge clk);
    #1 rst = 1'b0;
    cyc = 0;
    @(negedge clk);
    while (ebreak !== 1'b1 && cyc < 2000) begin
      @(negedge clk);
      cyc++;
    end
    if (ebreak !== 1'b1) begin
      $display("%s: timed out after %0d cycles waiting for EBREAK", name, cyc);
      timed_out = 1'b1;
      errors++;
    end else begin
      // Halt must come at the EBREAK closing the program
      check_value("imem_addr", imem_addr, word_t'((n_prog - 1) * 4));
      hold = imem_addr;
      repeat (10) begin
        @(negedge clk);
        assert (ebreak === 1'b1 && imem_addr === hold)
        else begin
          $display("%0t: PC moved or ebreak dropped while halted", $time);
          errors++;
        end
      end
      assert (exp_q.size() == 0)
      else begin
        $display("%s: %0d expected stores never happened", name, exp_q.size());
        errors++;
      end
    end
    tests++;
    if (errors == err0) begin
      $display("test %s: passed", name);
    end else begin
      failed++;
      $display("test %s: failed with %0d errors", name, errors - err0);
    end
  endtask

  // --------------------
  // Tests
  // --------------------
  task automatic test_alu();
    word_t a;
    word_t b;
    word_t r;
    start_program();
    repeat (4) begin
      next_rand(a);
      next_rand(b);
      load_const(1, a);
      load_const(2, b);
      for (int f = 0; f < 8; f++) begin
        emit(enc_r(7'b0, 2, 1, f, 3));
        store_word(3, alu_ref(f, 1'b0, a, b), 1'b1);
      end
      emit(enc_r(7'b0100000, 2, 1, 0, 3));
      store_word(3, alu_ref(0, 1'b1, a, b), 1'b1);
      emit(enc_r(7'b0100000, 2, 1, 5, 3));
      store_word(3, alu_ref(5, 1'b1, a, b), 1'b1);
      for (int f = 0; f < 8; f++) begin
        if (f != 1 && f != 5) begin
          next_rand(r);
          emit(enc_i(r[11:0], 1, f, 3, op_imm));
          store_word(3, alu_ref(f, 1'b0, a, sext12(r[11:0])), 1'b1);
        end
      end
      next_rand(r);
      emit(enc_i({7'b0, r[4:0]}, 1, 1, 3, op_imm));
      store_word(3, alu_ref(1, 1'b0, a, {27'b0, r[4:0]}), 1'b1);
      emit(enc_i({7'b0, r[4:0]}, 1, 5, 3, op_imm));
      store_word(3, alu_ref(5, 1'b0, a, {27'b0, r[4:0]}), 1'b1);
      emit(enc_i({7'b0100000, r[4:0]}, 1, 5, 3, op_imm));
      store_word(3, alu_ref(5, 1'b1, a, {27'b0, r[4:0]}), 1'b1);
    end
    // x0 ignores the write
    emit(enc_i(12'd5, 1, 0, 0, op_imm));
    store_word(0, 32'h0, 1'b1);
    run_program("alu");
  endtask

  task automatic test_branch();
    word_t a;
    word_t b;
    word_t pa [3];
    word_t pb [3];
    int marker;
    start_program();
    next_rand(a);
    pa[0] = a;
    pb[0] = a;
    next_rand(a);
    next_rand(b);
    pa[1] = a | 32'h8000_0000;
    pb[1] = b & 32'h7fff_ffff;
    pa[2] = pb[1];
    pb[2] = pa[1];
    marker = 1;
    for (int p = 0; p < 3; p++) begin
      load_const(1, pa[p]);
      load_const(2, pb[p]);
      for (int f = 0; f < 8; f++) begin
        if (f != 2 && f != 3) begin
          emit(enc_i(12'(marker), 0, 0, 5, op_imm));
          emit(enc_b(13'd8, 2, 1, f));
          store_word(5, word_t'(marker), !branch_ref(f, pa[p], pb[p]));
          marker++;
        end
      end
    end
    run_program("branch");
  endtask

  task automatic test_store();
    word_t v;
    start_program();
    next_rand(v);
    load_const(6, v);
    for (int off = 0; off < 4; off++) begin
      emit(enc_s(12'(32'h100 + off), 6, 0, 0));
      expect_store(32'h100 + off, {4{v[7:0]}}, strb_t'(4'b0001 << off));
    end
    for (int off = 0; off < 4; off += 2) begin
      emit(enc_s(12'(32'h100 + off), 6, 0, 1));
      expect_store(32'h100 + off, {2{v[15:0]}}, strb_t'(4'b0011 << off));
    end
    emit(enc_s(12'h104, 6, 0, 2));
    expect_store(32'h104, v, 4'b1111);
    run_program("store");
  endtask

  task automatic test_load();
    logic legal;
    start_program();
    for (int w = 16; w < 18; w++) begin
      for (int off = 0; off < 4; off++) begin
        for (int f = 0; f < 8; f++) begin
          legal = (f == 0 || f == 4) || ((f == 1 || f == 5) && off % 2 == 0) ||
                  (f == 2 && off == 0);
          if (legal) begin
            emit(enc_i(12'(w * 4 + off), 0, f, 7, op_load));
            store_word(7, ld_ref(f, ram_pattern(w), off), 1'b1);
          end
        end
      end
    end
    run_program("load");
  endtask

  task automatic test_jump();
    int j0;
    int k;
    instr_t poison;
    start_program();
    poison = enc_s(12'h3f0, 0, 0, 2);
    j0 = n_prog;
    emit(enc_j(21'd8, 8));
    emit(poison);
    store_word(8, word_t'(j0 * 4 + 4), 1'b1);
    // Odd target, so bit 0 must be cleared
    k = n_prog + 2;
    load_const(9, word_t'((k + 2) * 4 + 1));
    emit(enc_i(12'd0, 9, 0, 10, op_jalr));
    emit(poison);
    store_word(10, word_t'(k * 4 + 4), 1'b1);
    run_program("jump_halt");
  endtask

  initial begin
    rst = 1'b1;
    rst_q = 1'b0;
    rnd = 32'h8130b5a9;
    errors = 0;
    tests = 0;
    failed = 0;
    timed_out = 1'b0;
    for (int i = 0; i < 256; i++) begin
      u_mem.ram[i] = ram_pattern(i);
    end
    start_program();
    // Store at address 0 sits on the bus for the whole reset
    store_word(0, 32'h0, 1'b1);
    run_program("reset");
    test_alu();
    test_branch();
    test_store();
    test_load();
    test_jump();
    $display("%0d tests run, %0d failed, %0d errors", tests, failed, errors);
    if (errors == 0 && !timed_out) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- rv_core.f
hw/rv_pkg.sv
hw/rv_pc.sv
hw/rv_idec.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_bcmp.sv
hw/rv_mem_fmt.sv
hw/rv_core.sv
bench/tb_mem.sv
bench/tb_rv_core.sv

//--- run.sh
#!/bin/sh
# Build and run the rv_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_rv_core \
  -f rv_core.f \
  -o sim_rv_core

./obj_dir/sim_rv_core | tee sim.log

if grep -q "Test FAILED" sim.log; then
  exit 1
fi
grep -q "Test OK" sim.log
